/* rtl/procPkg.sv */
`default_nettype none

package procPkg;

	localparam int dataW = 16;
	localparam int regAddrW = 3;

	// Instruction bits 15 to 11
	typedef enum logic [4:0] {
		opHalt = 5'b00000,
		opNop  = 5'b00001,
		opJ    = 5'b00100,
		opJal  = 5'b00110,
		opAddi = 5'b01000,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opSt   = 5'b10000,
		opLd   = 5'b10001,
		opAdd  = 5'b11000,
		opSub  = 5'b11001,
		opAnd  = 5'b11010,
		opXor  = 5'b11011,
		opSeq  = 5'b11100,
		opSlt  = 5'b11101
	} opcodeT;

	// Register forms reuse their low opcode bits as the ALU op
	typedef enum logic [2:0] {
		aluAdd   = 3'b000,
		aluSub   = 3'b001,
		aluAnd   = 3'b010,
		aluXor   = 3'b011,
		aluSeq   = 3'b100,
		aluSlt   = 3'b101,
		aluPassB = 3'b110
	} aluOpT;

	typedef enum logic [1:0] {
		wbAlu = 2'b00,
		wbMem = 2'b01,
		wbPc  = 2'b10
	} wbSelT;

	typedef struct packed {
		aluOpT aluOp;
		logic  useImm;
		logic  memRead;
		logic  memWrite;
		logic  regWrite;
		wbSelT wbSel;
		logic  halt;
	} ctrlT;

	typedef struct packed {
		logic             valid;
		logic [dataW-1:0] instr;
		logic [dataW-1:0] pcPlusTwo;
	} ifIdT;

	typedef struct packed {
		logic                valid;
		ctrlT                ctrl;
		logic [dataW-1:0]    rsData;
		logic [dataW-1:0]    rtData;
		logic [dataW-1:0]    immExt;
		logic [regAddrW-1:0] destReg;
		logic [dataW-1:0]    pcPlusTwo;
	} idExT;

	typedef struct packed {
		logic                valid;
		ctrlT                ctrl;
		logic [dataW-1:0]    aluOut;
		logic [dataW-1:0]    storeData;
		logic [regAddrW-1:0] destReg;
		logic [dataW-1:0]    pcPlusTwo;
	} exMemT;

	typedef struct packed {
		logic                valid;
		logic                regWrite;
		logic                halt;
		logic [regAddrW-1:0] destReg;
		logic [dataW-1:0]    wbData;
	} memWbT;

endpackage

`default_nettype wire

/* rtl/pipeReg.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    arstN,
	input  logic    stall,
	input  logic    flush,
	input  payloadT d,
	output payloadT q
);

	// All-zero payload is a bubble since valid is low
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (!stall) begin
			if (flush) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch #(
	parameter int imemAddrW = 8
) (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      stall,
	input  logic                      redirect,
	input  logic [procPkg::dataW-1:0] target,
	input  logic                      haltSeen,
	input  logic                      imemWrite,
	input  logic [imemAddrW-1:0]      imemAddr,
	input  logic [procPkg::dataW-1:0] imemData,
	output procPkg::ifIdT             ifOut
);

	logic [procPkg::dataW-1:0] pc;
	logic [procPkg::dataW-1:0] pcPlusTwo;
	logic [procPkg::dataW-1:0] imem [2**imemAddrW];

	assign pcPlusTwo = pc + 16'd2;

	// Load port, used by the testbench while reset is held
	always_ff @(posedge clk) begin
		if (imemWrite) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stall && !haltSeen) begin
			if (redirect) begin
				pc <= target;
			end else begin
				pc <= pcPlusTwo;
			end
		end
	end

	always_comb begin
		ifOut.valid = !haltSeen;
		ifOut.instr = imem[pc[imemAddrW:1]];
		ifOut.pcPlusTwo = pcPlusTwo;
	end

endmodule

`default_nettype wire

/* rtl/decode.sv */
`timescale 1ns/100ps
`default_nettype none

module decode (
	input  logic                         clk,
	input  logic                         arstN,
	input  procPkg::ifIdT                ifId,
	input  procPkg::memWbT               memWb,
	output procPkg::idExT                idOut,
	output logic                         redirect,
	output logic [procPkg::dataW-1:0]    target,
	output logic                         haltSeen,
	output logic [procPkg::regAddrW-1:0] rsAddr,
	output logic [procPkg::regAddrW-1:0] rtAddr,
	output logic                         rsUsed,
	output logic                         rtUsed,
	output logic                         err
);

	logic [2**procPkg::regAddrW-1:0][procPkg::dataW-1:0] regs;
	procPkg::opcodeT                 opcode;
	procPkg::ctrlT                   ctrl;
	logic                            live;
	logic                            illegal;
	logic                            taken;
	logic                            readsRs;
	logic                            readsRt;
	logic                            wbWrite;
	logic                            errLatched;
	logic [procPkg::regAddrW-1:0]    destReg;
	logic [procPkg::dataW-1:0]       rsData;
	logic [procPkg::dataW-1:0]       rtData;
	logic [procPkg::dataW-1:0]       imm5Ext;
	logic [procPkg::dataW-1:0]       disp8Ext;
	logic [procPkg::dataW-1:0]       disp11Ext;

	assign opcode = procPkg::opcodeT'(ifId.instr[15:11]);
	assign rsAddr = ifId.instr[10:8];
	assign rtAddr = ifId.instr[7:5];
	assign imm5Ext = {{(procPkg::dataW-5){ifId.instr[4]}}, ifId.instr[4:0]};
	assign disp8Ext = {{(procPkg::dataW-8){ifId.instr[7]}}, ifId.instr[7:0]};
	assign disp11Ext = {{(procPkg::dataW-11){ifId.instr[10]}}, ifId.instr[10:0]};

	// Anything fetched behind a HALT is dropped here
	assign live = ifId.valid && !haltSeen;
	assign wbWrite = memWb.valid && memWb.regWrite;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regs <= '0;
		end else if (wbWrite) begin
			regs[memWb.destReg] <= memWb.wbData;
		end
	end

	// Write-before-read
	assign rsData = (wbWrite && memWb.destReg == rsAddr) ? memWb.wbData : regs[rsAddr];
	assign rtData = (wbWrite && memWb.destReg == rtAddr) ? memWb.wbData : regs[rtAddr];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = procPkg::aluPassB;
		ctrl.wbSel = procPkg::wbAlu;
		destReg = ifId.instr[4:2];
		readsRs = 1'b0;
		readsRt = 1'b0;
		taken = 1'b0;
		illegal = 1'b0;
		target = ifId.pcPlusTwo + (disp8Ext << 1);
		case (opcode)
			procPkg::opAdd, procPkg::opSub, procPkg::opAnd,
			procPkg::opXor, procPkg::opSeq, procPkg::opSlt: begin
				ctrl.aluOp = procPkg::aluOpT'(ifId.instr[13:11]);
				ctrl.regWrite = 1'b1;
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			procPkg::opAddi, procPkg::opLd: begin
				ctrl.aluOp = procPkg::aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = (opcode == procPkg::opLd);
				ctrl.wbSel = (opcode == procPkg::opLd) ? procPkg::wbMem : procPkg::wbAlu;
				destReg = ifId.instr[7:5];
				readsRs = 1'b1;
			end
			procPkg::opSt: begin
				ctrl.aluOp = procPkg::aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			procPkg::opBeqz: begin
				readsRs = 1'b1;
				taken = (rsData == '0);
			end
			procPkg::opBnez: begin
				readsRs = 1'b1;
				taken = (rsData != '0);
			end
			procPkg::opJ, procPkg::opJal: begin
				taken = 1'b1;
				target = ifId.pcPlusTwo + (disp11Ext << 1);
				ctrl.regWrite = (opcode == procPkg::opJal);
				ctrl.wbSel = procPkg::wbPc;
				destReg = 3'd7;
			end
			procPkg::opHalt: ctrl.halt = 1'b1;
			procPkg::opNop: ;
			default: illegal = 1'b1;
		endcase
	end

	assign redirect = live && taken;
	assign rsUsed = live && readsRs;
	assign rtUsed = live && readsRt;
	assign err = errLatched;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			haltSeen <= 1'b0;
			errLatched <= 1'b0;
		end else begin
			if (live && opcode == procPkg::opHalt) begin
				haltSeen <= 1'b1;
			end
			if (live && illegal) begin
				errLatched <= 1'b1;
			end
		end
	end

	always_comb begin
		idOut.valid = live && !illegal;
		idOut.ctrl = ctrl;
		idOut.rsData = rsData;
		idOut.rtData = rtData;
		idOut.immExt = imm5Ext;
		idOut.destReg = destReg;
		idOut.pcPlusTwo = ifId.pcPlusTwo;
	end

endmodule

`default_nettype wire

/* rtl/hazardDetection.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardDetection (
	input  logic                         rsUsed,
	input  logic                         rtUsed,
	input  logic [procPkg::regAddrW-1:0] rsAddr,
	input  logic [procPkg::regAddrW-1:0] rtAddr,
	input  logic [procPkg::regAddrW-1:0] exDest,
	input  logic                         exWrites,
	input  logic [procPkg::regAddrW-1:0] memDest,
	input  logic                         memWrites,
	output logic                         stall
);

	logic rsHit;
	logic rtHit;

	// Write-back needs no check, the register file bypasses it
	assign rsHit = rsUsed && ((exWrites && exDest == rsAddr) || (memWrites && memDest == rsAddr));
	assign rtHit = rtUsed && ((exWrites && exDest == rtAddr) || (memWrites && memDest == rtAddr));

	assign stall = rsHit || rtHit;

endmodule

`default_nettype wire

/* rtl/execute.sv */
`timescale 1ns/100ps
`default_nettype none

module execute (
	input  procPkg::idExT  idEx,
	output procPkg::exMemT exOut
);

	logic [procPkg::dataW-1:0] opB;
	logic [procPkg::dataW-1:0] aluOut;

	assign opB = idEx.ctrl.useImm ? idEx.immExt : idEx.rtData;

	always_comb begin
		aluOut = '0;
		case (idEx.ctrl.aluOp)
			procPkg::aluAdd: aluOut = idEx.rsData + opB;
			procPkg::aluSub: aluOut = idEx.rsData - opB;
			procPkg::aluAnd: aluOut = idEx.rsData & opB;
			procPkg::aluXor: aluOut = idEx.rsData ^ opB;
			procPkg::aluSeq: aluOut[0] = (idEx.rsData == opB);
			procPkg::aluSlt: aluOut[0] = ($signed(idEx.rsData) < $signed(opB));
			procPkg::aluPassB: aluOut = opB;
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		exOut.valid = idEx.valid;
		exOut.ctrl = idEx.ctrl;
		exOut.aluOut = aluOut;
		exOut.storeData = idEx.rtData;
		exOut.destReg = idEx.destReg;
		exOut.pcPlusTwo = idEx.pcPlusTwo;
	end

endmodule

`default_nettype wire

/* rtl/memory.sv */
`timescale 1ns/100ps
`default_nettype none

module memory #(
	parameter int dmemAddrW = 8
) (
	input  logic                      clk,
	input  logic                      arstN,
	input  procPkg::exMemT            exMem,
	output procPkg::memWbT            wbOut,
	output logic                      storeValid,
	output logic [procPkg::dataW-1:0] storeAddr,
	output logic [procPkg::dataW-1:0] storeData
);

	logic [2**dmemAddrW-1:0][procPkg::dataW-1:0] dmem;
	logic [dmemAddrW-1:0]      wordAddr;
	logic [procPkg::dataW-1:0] loadData;

	// Byte address from the ALU, memory is word indexed
	assign wordAddr = exMem.aluOut[dmemAddrW:1];
	assign storeValid = exMem.valid && exMem.ctrl.memWrite;
	assign storeAddr = exMem.aluOut;
	assign storeData = exMem.storeData;
	assign loadData = exMem.ctrl.memRead ? dmem[wordAddr] : '0;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dmem <= '0;
		end else if (storeValid) begin
			dmem[wordAddr] <= storeData;
		end
	end

	always_comb begin
		wbOut.valid = exMem.valid;
		wbOut.regWrite = exMem.ctrl.regWrite;
		wbOut.halt = exMem.ctrl.halt;
		wbOut.destReg = exMem.destReg;
		case (exMem.ctrl.wbSel)
			procPkg::wbMem: wbOut.wbData = loadData;
			procPkg::wbPc: wbOut.wbData = exMem.pcPlusTwo;
			default: wbOut.wbData = exMem.aluOut;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/proc.sv */
`timescale 1ns/100ps
`default_nettype none

module proc #(
	parameter int imemAddrW = 8,
	parameter int dmemAddrW = 8
) (
	input  logic                         clk,
	input  logic                         arstN,
	input  logic                         imemWrite,
	input  logic [imemAddrW-1:0]         imemAddr,
	input  logic [procPkg::dataW-1:0]    imemData,
	output logic                         wbValid,
	output logic [procPkg::regAddrW-1:0] wbReg,
	output logic [procPkg::dataW-1:0]    wbData,
	output logic                         storeValid,
	output logic [procPkg::dataW-1:0]    storeAddr,
	output logic [procPkg::dataW-1:0]    storeData,
	output logic                         halted,
	output logic                         err
);

	procPkg::ifIdT  ifF, ifD;
	procPkg::idExT  idD, idX;
	procPkg::exMemT exX, exM;
	procPkg::memWbT memM, memW;

	logic                         stall;
	logic                         redirect;
	logic [procPkg::dataW-1:0]    target;
	logic                         haltSeen;
	logic [procPkg::regAddrW-1:0] rsAddr;
	logic [procPkg::regAddrW-1:0] rtAddr;
	logic                         rsUsed;
	logic                         rtUsed;

	fetch #(.imemAddrW(imemAddrW)) fetchStage (
		.clk(clk), .arstN(arstN), .stall(stall), .redirect(redirect), .target(target),
		.haltSeen(haltSeen), .imemWrite(imemWrite), .imemAddr(imemAddr),
		.imemData(imemData), .ifOut(ifF)
	);

	// Taken redirect drops the instruction fetched behind it
	pipeReg #(.payloadT(procPkg::ifIdT)) ifIdReg (
		.clk(clk), .arstN(arstN), .stall(stall), .flush(redirect), .d(ifF), .q(ifD)
	);

	decode decodeStage (
		.clk(clk), .arstN(arstN), .ifId(ifD), .memWb(memW), .idOut(idD),
		.redirect(redirect), .target(target), .haltSeen(haltSeen),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsUsed(rsUsed), .rtUsed(rtUsed), .err(err)
	);

	hazardDetection hdu (
		.rsUsed(rsUsed), .rtUsed(rtUsed), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.exDest(idX.destReg), .exWrites(idX.valid && idX.ctrl.regWrite),
		.memDest(exM.destReg), .memWrites(exM.valid && exM.ctrl.regWrite),
		.stall(stall)
	);

	// Stall inserts a bubble into execute
	pipeReg #(.payloadT(procPkg::idExT)) idExReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(stall), .d(idD), .q(idX)
	);

	execute executeStage (
		.idEx(idX), .exOut(exX)
	);

	pipeReg #(.payloadT(procPkg::exMemT)) exMemReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(exX), .q(exM)
	);

	memory #(.dmemAddrW(dmemAddrW)) memoryStage (
		.clk(clk), .arstN(arstN), .exMem(exM), .wbOut(memM),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
	);

	pipeReg #(.payloadT(procPkg::memWbT)) memWbReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0), .d(memM), .q(memW)
	);

	assign wbValid = memW.valid && memW.regWrite;
	assign wbReg = memW.destReg;
	assign wbData = memW.wbData;

	// Set once HALT retires, held until reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halted <= 1'b0;
		end else if (memW.valid && memW.halt) begin
			halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* dv/procAssertions.sv */
`timescale 1ns/100ps
`default_nettype none

module procAssertions (
	input logic                      clk,
	input logic                      arstN,
	input logic                      wbValid,
	input logic                      halted,
	input logic                      stall,
	input logic                      redirect,
	input logic [procPkg::dataW-1:0] pc
);

	noWriteAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
		halted |-> !wbValid)
		else $error("register write retired after halt");

	// A hazard clears once the producer leaves memory
	stallBounded: assert property (@(posedge clk) disable iff (!arstN)
		stall && $past(stall) |=> !stall)
		else $error("stall held longer than two cycles");

	redirectWaits: assert property (@(posedge clk) disable iff (!arstN)
		stall && redirect |=> pc == $past(pc))
		else $error("redirect taken while decode was stalled");

endmodule

bind proc procAssertions procChecks (
	.clk(clk), .arstN(arstN), .wbValid(wbValid), .halted(halted), .stall(stall),
	.redirect(redirect), .pc(fetchStage.pc)
);

`default_nettype wire

/* dv/procTb.sv */
`timescale 1ns/100ps
`default_nettype none

module procTb;

	localparam int numProgs = 6;
	localparam int maxWords = 12;
	localparam int resetCycles = 16;
	localparam int tailCycles = 6;
	localparam int cycleLimit = numProgs * (resetCycles + 60);
	localparam int kNone = 0;
	localparam int kWrite = 1;
	localparam int kStore = 2;
	localparam logic [15:0] haltWord = {procPkg::opHalt, 11'd0};
	localparam logic [15:0] nopWord = {procPkg::opNop, 11'd0};

	logic        clk;
	logic        arstN;
	logic        imemWrite;
	logic [7:0]  imemAddr;
	logic [15:0] imemData;
	logic        wbValid;
	logic [2:0]  wbReg;
	logic [15:0] wbData;
	logic        storeValid;
	logic [15:0] storeAddr;
	logic [15:0] storeData;
	logic        halted;
	logic        err;

	// One row per instruction word, with the write or store it must retire
	logic [15:0] rowWord [numProgs*maxWords];
	int          rowKind [numProgs*maxWords];
	logic [15:0] rowA [numProgs*maxWords];
	logic [15:0] rowB [numProgs*maxWords];
	int          codeLen [numProgs];
	logic        errExp [numProgs];
	int          curProg;
	int          errCount;
	int          cycleCount;

	logic [2:0]  wrRegQ [$];
	logic [15:0] wrValQ [$];
	logic [15:0] stAddrQ [$];
	logic [15:0] stDataQ [$];

	proc #(.imemAddrW(8), .dmemAddrW(8)) uut (
		.clk(clk), .arstN(arstN), .imemWrite(imemWrite), .imemAddr(imemAddr),
		.imemData(imemData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted), .err(err)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd);
		encR = {op, rs, rt, rd, 2'b00};
	endfunction

	function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm);
		encI = {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] encB(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] disp);
		encB = {op, rs, disp};
	endfunction

	function automatic logic [15:0] encJ(input logic [4:0] op, input logic [10:0] disp);
		encJ = {op, disp};
	endfunction

	task automatic startProgram(input logic expectErr);
		curProg++;
		codeLen[curProg] = 0;
		errExp[curProg] = expectErr;
	endtask

	task automatic addRow(input logic [15:0] word, input int kind, input logic [15:0] a,
		input logic [15:0] b);
		int idx;
		idx = curProg * maxWords + codeLen[curProg];
		rowWord[idx] = word;
		rowKind[idx] = kind;
		rowA[idx] = a;
		rowB[idx] = b;
		codeLen[curProg]++;
	endtask

	task automatic buildTable();
		curProg = -1;
		// Arithmetic on dependent registers
		startProgram(1'b0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd13), kWrite, 16'd1, 16'h000D);
		addRow(encI(procPkg::opAddi, 3'd1, 3'd2, -5'sd6), kWrite, 16'd2, 16'h0007);
		addRow(encR(procPkg::opAdd, 3'd1, 3'd2, 3'd3), kWrite, 16'd3, 16'h0014);
		addRow(encR(procPkg::opSub, 3'd2, 3'd1, 3'd4), kWrite, 16'd4, 16'hFFFA);
		addRow(encR(procPkg::opAnd, 3'd4, 3'd1, 3'd5), kWrite, 16'd5, 16'h0008);
		addRow(encR(procPkg::opXor, 3'd5, 3'd3, 3'd6), kWrite, 16'd6, 16'h001C);
		addRow(haltWord, kNone, 16'd0, 16'd0);
		// Compare-set, signed
		startProgram(1'b0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd3), kWrite, 16'd1, 16'h0003);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd2, -5'sd4), kWrite, 16'd2, 16'hFFFC);
		addRow(encR(procPkg::opSeq, 3'd1, 3'd1, 3'd3), kWrite, 16'd3, 16'h0001);
		addRow(encR(procPkg::opSeq, 3'd1, 3'd2, 3'd4), kWrite, 16'd4, 16'h0000);
		addRow(encR(procPkg::opSlt, 3'd2, 3'd1, 3'd5), kWrite, 16'd5, 16'h0001);
		addRow(encR(procPkg::opSlt, 3'd1, 3'd2, 3'd6), kWrite, 16'd6, 16'h0000);
		addRow(encR(procPkg::opSlt, 3'd1, 3'd1, 3'd7), kWrite, 16'd7, 16'h0000);
		addRow(haltWord, kNone, 16'd0, 16'd0);
		// Store, load back, then load-use
		startProgram(1'b0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd6), kWrite, 16'd1, 16'h0006);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd2, -5'sd7), kWrite, 16'd2, 16'hFFF9);
		addRow(encI(procPkg::opSt, 3'd1, 3'd2, 5'd4), kStore, 16'h000A, 16'hFFF9);
		addRow(encI(procPkg::opLd, 3'd1, 3'd3, 5'd4), kWrite, 16'd3, 16'hFFF9);
		addRow(encR(procPkg::opAdd, 3'd3, 3'd1, 3'd4), kWrite, 16'd4, 16'hFFFF);
		addRow(haltWord, kNone, 16'd0, 16'd0);
		// Branches and jumps, skipped rows must never retire
		startProgram(1'b0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd0), kWrite, 16'd1, 16'h0000);
		// BEQZ stalls on r1 while its redirect is already raised
		addRow(encB(procPkg::opBeqz, 3'd1, 8'd1), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd2, 5'd9), kNone, 16'd0, 16'd0);
		addRow(encB(procPkg::opBnez, 3'd0, 8'd2), kNone, 16'd0, 16'd0);
		addRow(encJ(procPkg::opJal, 11'd2), kWrite, 16'd7, 16'h000A);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd3, 5'd5), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd3, 5'd6), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd1, 3'd4, 5'd2), kWrite, 16'd4, 16'h0002);
		addRow(encJ(procPkg::opJ, 11'd1), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd5, 5'd7), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd7, 3'd6, 5'd1), kWrite, 16'd6, 16'h000B);
		addRow(haltWord, kNone, 16'd0, 16'd0);
		// Words after HALT are fetched but never retire
		startProgram(1'b0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd4), kWrite, 16'd1, 16'h0004);
		addRow(encI(procPkg::opAddi, 3'd1, 3'd2, 5'd1), kWrite, 16'd2, 16'h0005);
		addRow(haltWord, kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd3, 5'd1), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opSt, 3'd0, 3'd1, 5'd0), kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd4, 5'd2), kNone, 16'd0, 16'd0);
		// Illegal opcode 11111 in the middle
		startProgram(1'b1);
		addRow(encI(procPkg::opAddi, 3'd0, 3'd1, 5'd2), kWrite, 16'd1, 16'h0002);
		addRow(16'hF800, kNone, 16'd0, 16'd0);
		addRow(encI(procPkg::opAddi, 3'd1, 3'd2, 5'd3), kWrite, 16'd2, 16'h0005);
		addRow(nopWord, kNone, 16'd0, 16'd0);
		addRow(encR(procPkg::opAdd, 3'd2, 3'd1, 3'd3), kWrite, 16'd3, 16'h0007);
		addRow(haltWord, kNone, 16'd0, 16'd0);
	endtask

	task automatic queueExpected(input int p);
		int i;
		int idx;
		wrRegQ.delete();
		wrValQ.delete();
		stAddrQ.delete();
		stDataQ.delete();
		for (i = 0; i < codeLen[p]; i++) begin
			idx = p * maxWords + i;
			if (rowKind[idx] == kWrite) begin
				wrRegQ.push_back(rowA[idx][2:0]);
				wrValQ.push_back(rowB[idx]);
			end else if (rowKind[idx] == kStore) begin
				stAddrQ.push_back(rowA[idx]);
				stDataQ.push_back(rowB[idx]);
			end
		end
	endtask

	// Called at a rising edge with reset already asserted
	task automatic loadProgram(input int p);
		int i;
		for (i = 0; i < resetCycles; i++) begin
			imemWrite <= 1'b1;
			imemAddr <= 8'(i);
			imemData <= (i < codeLen[p]) ? rowWord[p * maxWords + i] : haltWord;
			@(posedge clk);
		end
		imemWrite <= 1'b0;
	endtask

	task automatic checkRetire();
		logic [2:0]  expReg;
		logic [15:0] expVal;
		logic [15:0] expAddr;
		if (wbValid) begin
			if (wrRegQ.size() == 0) begin
				$display("Unexpected register write to r%0d at %0t", wbReg, $time);
				errCount++;
			end else begin
				expReg = wrRegQ.pop_front();
				expVal = wrValQ.pop_front();
				if (wbReg !== expReg) begin
					$display("Fail t=%0t wbReg expected %0d got %0d", $time, expReg, wbReg);
					errCount++;
				end
				if (wbData !== expVal) begin
					$display("Fail t=%0t wbData expected %h got %h", $time, expVal, wbData);
					errCount++;
				end
			end
		end
		if (storeValid) begin
			if (stAddrQ.size() == 0) begin
				$display("Unexpected store to %h at %0t", storeAddr, $time);
				errCount++;
			end else begin
				expAddr = stAddrQ.pop_front();
				expVal = stDataQ.pop_front();
				if (storeAddr !== expAddr) begin
					$display("Fail t=%0t storeAddr expected %h got %h", $time, expAddr, storeAddr);
					errCount++;
				end
				if (storeData !== expVal) begin
					$display("Fail t=%0t storeData expected %h got %h", $time, expVal, storeData);
					errCount++;
				end
			end
		end
	endtask

	initial begin
		int p;
		arstN = 1'b0;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errCount = 0;
		buildTable();
		@(posedge clk);
		for (p = 0; p < numProgs; p++) begin
			arstN <= 1'b0;
			queueExpected(p);
			loadProgram(p);
			arstN <= 1'b1;
			@(negedge clk);
			if (wbValid || storeValid || halted || err) begin
				$display("Outputs not all low after reset in program %0d", p);
				errCount++;
			end
			do begin
				@(negedge clk);
				checkRetire();
			end while (!halted);
			repeat (tailCycles) begin
				@(negedge clk);
				if (wbValid || storeValid) begin
					$display("Write or store retired after halt at %0t", $time);
					errCount++;
				end
				if (!halted) begin
					$display("Halted flag dropped at %0t", $time);
					errCount++;
				end
			end
			if (wrRegQ.size() != 0 || stAddrQ.size() != 0) begin
				$display("Program %0d ended with %0d writes and %0d stores missing", p,
					wrRegQ.size(), stAddrQ.size());
				errCount++;
			end
			if (err !== errExp[p]) begin
				$display("Fail t=%0t err expected %b got %b", $time, errExp[p], err);
				errCount++;
			end
			@(posedge clk);
		end
		$display("Errors: %0d", errCount);
		if (errCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, program did not halt", cycleCount);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
rtl/procPkg.sv
rtl/pipeReg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/hazardDetection.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
dv/procAssertions.sv
dv/procTb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - files:
      - rtl/procPkg.sv
      - rtl/pipeReg.sv
      - rtl/fetch.sv
      - rtl/decode.sv
      - rtl/hazardDetection.sv
      - rtl/execute.sv
      - rtl/memory.sv
      - rtl/proc.sv
  - target: simulation
    files:
      - dv/procAssertions.sv
      - dv/procTb.sv
